// ==== common/rtab_settings.svh ====
// Size settings of the replay table.
// Include this header wherever a table dimension is needed.
// Widths follow from these values, so keep RTAB_PTR_W equal to log2 of
// RTAB_ENTRIES when the entry count changes.

`ifndef RTAB_SETTINGS_SVH
`define RTAB_SETTINGS_SVH

// Number of requests the table can hold
`define RTAB_ENTRIES 4

// Width of an entry index
`define RTAB_PTR_W 2

// Width of a cache-line index
`define RTAB_NLINE_W 8

// Width of the request payload kept with each entry
`define RTAB_DATA_W 16

`endif

// ==== common/rtab_pkg.sv ====
// Types shared by the replay table blocks.
// Modules import it with a wildcard import in their header.

`default_nettype none

`include "rtab_settings.svh"

package rtab_pkg;

    // Cache-line index of a request
    typedef logic [`RTAB_NLINE_W-1:0] rtab_nline_t;

    // Index of a table entry
    typedef logic [`RTAB_PTR_W-1:0] rtab_ptr_t;

    // One bit per table entry
    typedef logic [`RTAB_ENTRIES-1:0] rtab_bv_t;

    // Request payload
    typedef logic [`RTAB_DATA_W-1:0] rtab_data_t;

    // A stored request
    typedef struct packed {
        rtab_nline_t nline;
        rtab_data_t  data;
    } rtab_req_t;

    // States of the pop walker
    //   pop_head      offer a ready list head
    //   pop_next      offer the next entry of the list being walked
    //   pop_next_wait hold that entry until it is accepted
    typedef enum logic [1:0] {
        pop_head,
        pop_next,
        pop_next_wait
    } rtab_pop_state_e;

endpackage

`default_nettype wire

// ==== rtab/rtab_match.sv ====
// Line matcher of the replay table.
// Compares the checked and refilled lines with every stored request and
// picks the lowest free entry for the next allocation.

`timescale 1ns/1ns
`default_nettype none

`include "rtab_settings.svh"

module rtab_match
    import rtab_pkg::*;
(
    input  wire rtab_nline_t                    check_nline_i,
    input  wire logic                           refill_i,
    input  wire rtab_nline_t                    refill_nline_i,
    input  wire rtab_req_t [`RTAB_ENTRIES-1:0]  req_i,
    input  wire rtab_bv_t                       valid_i,
    input  wire rtab_bv_t                       tail_i,
    output logic                                check_hit_o,
    output rtab_bv_t                            tail_match_o,
    output rtab_bv_t                            refill_match_o,
    output rtab_bv_t                            free_onehot_o
);

    rtab_bv_t check_match;
    rtab_bv_t free;

    // Parallel line compare over all valid entries
    always_comb begin
        for (int i = 0; i < `RTAB_ENTRIES; i++) begin
            check_match[i]    = valid_i[i] && (req_i[i].nline == check_nline_i);
            refill_match_o[i] = valid_i[i] && refill_i && (req_i[i].nline == refill_nline_i);
        end
    end

    assign check_hit_o  = |check_match;

    // Only the tail of a list may take a link
    assign tail_match_o = check_match & tail_i;

    // Isolate the lowest clear valid bit
    assign free          = ~valid_i;
    assign free_onehot_o = free & (~free + rtab_bv_t'(1));

    // One list per line, so at most one tail can match
    always_comb begin
        assert ($onehot0(tail_match_o))
        else $error("rtab_match: several list tails hold the checked line");
    end

endmodule

`default_nettype wire

// ==== rtab/rtab_store.sv ====
// Entry store of the replay table.
// Keeps the requests, the next pointers and the per-entry valid, head, tail
// and miss-dependency flags. Flags change through set and reset vectors
// built from allocation, refill, hand-over, commit and rollback.

`timescale 1ns/1ns
`default_nettype none

`include "rtab_settings.svh"

module rtab_store
    import rtab_pkg::*;
(
    input  wire logic                           clk_i,
    input  wire logic                           rst_ni,
    input  wire logic                           alloc_i,
    input  wire logic                           alloc_link_i,
    input  wire rtab_req_t                      alloc_req_i,
    input  wire logic                           alloc_mshr_hit_i,
    input  wire rtab_bv_t                       free_onehot_i,
    input  wire rtab_bv_t                       tail_match_i,
    input  wire rtab_bv_t                       refill_match_i,
    input  wire rtab_bv_t                       take_i,
    input  wire logic                           pop_commit_i,
    input  wire rtab_ptr_t                      pop_commit_ptr_i,
    input  wire logic                           pop_rback_i,
    input  wire rtab_ptr_t                      pop_rback_ptr_i,
    input  wire logic                           pop_rback_mshr_hit_i,
    output rtab_req_t [`RTAB_ENTRIES-1:0]       req_o,
    output rtab_ptr_t [`RTAB_ENTRIES-1:0]       next_o,
    output rtab_bv_t                            valid_o,
    output rtab_bv_t                            tail_o,
    output rtab_bv_t                            ready_o,
    output logic                                full_o,
    output logic                                empty_o
);

    rtab_req_t [`RTAB_ENTRIES-1:0] req_q;
    rtab_ptr_t [`RTAB_ENTRIES-1:0] next_q;

    rtab_bv_t valid_q;
    rtab_bv_t head_q;
    rtab_bv_t tail_q;
    rtab_bv_t dep_q;
    rtab_bv_t take_q;

    rtab_bv_t alloc_bv;
    rtab_bv_t commit_bv;
    rtab_bv_t rback_bv;
    rtab_bv_t valid_set, valid_rst;
    rtab_bv_t head_set, head_rst;
    rtab_bv_t tail_set, tail_rst;
    rtab_bv_t dep_set, dep_rst;
    rtab_ptr_t free_ptr;
    logic      alloc;

    assign alloc    = alloc_i | alloc_link_i;
    assign alloc_bv = free_onehot_i & {`RTAB_ENTRIES{alloc}};

    // Index form of the free entry, written into the old tail on a link
    always_comb begin
        free_ptr = '0;
        for (int i = 0; i < `RTAB_ENTRIES; i++) begin
            if (free_onehot_i[i]) begin
                free_ptr = rtab_ptr_t'(i);
            end
        end
    end

    always_comb begin
        commit_bv = '0;
        rback_bv  = '0;
        if (pop_commit_i) begin
            commit_bv[pop_commit_ptr_i] = 1'b1;
        end
        if (pop_rback_i) begin
            rback_bv[pop_rback_ptr_i] = 1'b1;
        end
    end

    assign valid_set = alloc_bv;
    assign valid_rst = commit_bv;

    // A new list starts with a head; a linked entry waits behind the old tail
    assign head_set = (alloc_bv & {`RTAB_ENTRIES{alloc_i}}) | rback_bv;
    assign head_rst = (alloc_bv & {`RTAB_ENTRIES{alloc_link_i}}) | take_i;

    // New entries always become the tail
    assign tail_set = alloc_bv;
    assign tail_rst = tail_match_i & {`RTAB_ENTRIES{alloc_link_i}};

    assign dep_set = (alloc_bv & {`RTAB_ENTRIES{alloc_mshr_hit_i}}) |
                     (rback_bv & {`RTAB_ENTRIES{pop_rback_mshr_hit_i}});
    assign dep_rst = refill_match_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            dep_q   <= '0;
            take_q  <= '0;
        end else begin
            valid_q <= (valid_q & ~valid_rst) | valid_set;
            head_q  <= (head_q & ~head_rst) | head_set;
            tail_q  <= (tail_q & ~tail_rst) | tail_set;
            dep_q   <= (dep_q & ~dep_rst) | dep_set;
            take_q  <= take_i;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `RTAB_ENTRIES; i++) begin
            if (alloc_bv[i]) begin
                req_q[i] <= alloc_req_i;
            end
            if (alloc_link_i && tail_match_i[i]) begin
                next_q[i] <= free_ptr;
            end
        end
    end

    assign req_o   = req_q;
    assign next_o  = next_q;
    assign valid_o = valid_q;
    assign tail_o  = tail_q;
    assign ready_o = valid_q & head_q & ~dep_q;
    assign full_o  = &valid_q;
    assign empty_o = ~|valid_q;

    a_alloc_not_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc |-> !full_o)
    else $error("rtab_store: allocation while the table is full");

    a_commit_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_commit_i |-> valid_q[pop_commit_ptr_i])
    else $error("rtab_store: commit of an invalid entry");

    a_rback_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_rback_i |-> valid_q[pop_rback_ptr_i])
    else $error("rtab_store: rollback of an invalid entry");

    // Each handed-over entry gets exactly one commit or rollback next cycle
    a_take_closed: assert property (@(posedge clk_i) disable iff (!rst_ni)
        |take_q |-> ((pop_commit_i && take_q[pop_commit_ptr_i]) ^
                     (pop_rback_i && take_q[pop_rback_ptr_i])))
    else $error("rtab_store: transfer not followed by one commit or rollback");

endmodule

`default_nettype wire

// ==== rtab/rtab_pop.sv ====
// Pop walker of the replay table.
// Picks a ready list head round-robin, then follows the next pointers up
// to the tail, offering one entry per transfer on the pop handshake.
// take_o tells the store which entry left in the current cycle.

`timescale 1ns/1ns
`default_nettype none

`include "rtab_settings.svh"

module rtab_pop
    import rtab_pkg::*;
(
    input  wire logic                           clk_i,
    input  wire logic                           rst_ni,
    input  wire rtab_bv_t                       ready_i,
    input  wire rtab_bv_t                       tail_i,
    input  wire rtab_ptr_t [`RTAB_ENTRIES-1:0]  next_i,
    input  wire rtab_req_t [`RTAB_ENTRIES-1:0]  req_i,
    input  wire logic                           pop_ready_i,
    input  wire logic                           pop_rback_i,
    output logic                                pop_valid_o,
    output rtab_req_t                           pop_req_o,
    output rtab_ptr_t                           pop_ptr_o,
    output rtab_bv_t                            take_o
);

    rtab_pop_state_e state_q, state_d;
    rtab_ptr_t       next_q, next_d;
    rtab_ptr_t       rr_q;
    rtab_ptr_t       grant_ptr;
    logic            xfer;

    // Round-robin search starting at rr_q; lowest offset wins
    always_comb begin
        int idx;
        grant_ptr = '0;
        for (int k = `RTAB_ENTRIES - 1; k >= 0; k--) begin
            idx = (int'(rr_q) + k) % `RTAB_ENTRIES;
            if (ready_i[idx]) begin
                grant_ptr = rtab_ptr_t'(idx);
            end
        end
    end

    always_comb begin
        case (state_q)
            pop_head: pop_valid_o = |ready_i;
            pop_next, pop_next_wait: pop_valid_o = 1'b1;
            default: pop_valid_o = 1'b0;
        endcase
    end

    // Outside pop_head the offered entry is the registered next pointer
    assign pop_ptr_o = (state_q == pop_head) ? grant_ptr : next_q;
    assign pop_req_o = req_i[pop_ptr_o];
    assign xfer      = pop_valid_o && pop_ready_i;

    always_comb begin
        take_o = '0;
        if (xfer) begin
            take_o[pop_ptr_o] = 1'b1;
        end
    end

    always_comb begin
        state_d = state_q;
        next_d  = next_q;
        case (state_q)
            pop_head: begin
                if (xfer && !tail_i[pop_ptr_o]) begin
                    state_d = pop_next;
                    next_d  = next_i[pop_ptr_o];
                end
            end
            pop_next, pop_next_wait: begin
                if (state_q == pop_next && pop_rback_i) begin
                    // Previous entry is back at the head of its list
                    state_d = pop_head;
                end else if (xfer) begin
                    if (tail_i[pop_ptr_o]) begin
                        state_d = pop_head;
                    end else begin
                        state_d = pop_next;
                        next_d  = next_i[pop_ptr_o];
                    end
                end else begin
                    state_d = pop_next_wait;
                end
            end
            default: state_d = pop_head;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= pop_head;
            next_q  <= '0;
            rr_q    <= '0;
        end else begin
            state_q <= state_d;
            next_q  <= next_d;
            if (state_q == pop_head && xfer) begin
                rr_q <= grant_ptr + rtab_ptr_t'(1);
            end
        end
    end

    a_no_xfer_on_rback: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_rback_i |-> !xfer)
    else $error("rtab_pop: transfer accepted during a rollback");

endmodule

`default_nettype wire

// ==== verilog/rtab_top.sv ====
// Top level of the replay table.
// Connects the line matcher, the entry store and the pop walker. Requests
// that cannot be served are allocated here and replayed through the pop
// port; full_o is the back-pressure for allocation.

`timescale 1ns/1ns
`default_nettype none

`include "rtab_settings.svh"

module rtab_top
    import rtab_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_ni,
    input  wire logic        check_i,
    input  wire rtab_nline_t check_nline_i,
    output logic             check_hit_o,
    input  wire logic        alloc_i,
    input  wire logic        alloc_link_i,
    input  wire rtab_req_t   alloc_req_i,
    input  wire logic        alloc_mshr_hit_i,
    input  wire logic        refill_i,
    input  wire rtab_nline_t refill_nline_i,
    output logic             pop_valid_o,
    input  wire logic        pop_ready_i,
    output rtab_req_t        pop_req_o,
    output rtab_ptr_t        pop_ptr_o,
    input  wire logic        pop_commit_i,
    input  wire rtab_ptr_t   pop_commit_ptr_i,
    input  wire logic        pop_rback_i,
    input  wire rtab_ptr_t   pop_rback_ptr_i,
    input  wire logic        pop_rback_mshr_hit_i,
    output logic             full_o,
    output logic             empty_o
);

    rtab_req_t [`RTAB_ENTRIES-1:0] req;
    rtab_ptr_t [`RTAB_ENTRIES-1:0] next;
    rtab_bv_t                      valid;
    rtab_bv_t                      tail;
    rtab_bv_t                      ready;
    rtab_bv_t                      tail_match;
    rtab_bv_t                      refill_match;
    rtab_bv_t                      free_onehot;
    rtab_bv_t                      take;

    rtab_match i_rtab_match (
        .check_nline_i  (check_nline_i),
        .refill_i       (refill_i),
        .refill_nline_i (refill_nline_i),
        .req_i          (req),
        .valid_i        (valid),
        .tail_i         (tail),
        .check_hit_o    (check_hit_o),
        .tail_match_o   (tail_match),
        .refill_match_o (refill_match),
        .free_onehot_o  (free_onehot)
    );

    rtab_store i_rtab_store (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .alloc_i              (alloc_i),
        .alloc_link_i         (alloc_link_i),
        .alloc_req_i          (alloc_req_i),
        .alloc_mshr_hit_i     (alloc_mshr_hit_i),
        .free_onehot_i        (free_onehot),
        .tail_match_i         (tail_match),
        .refill_match_i       (refill_match),
        .take_i               (take),
        .pop_commit_i         (pop_commit_i),
        .pop_commit_ptr_i     (pop_commit_ptr_i),
        .pop_rback_i          (pop_rback_i),
        .pop_rback_ptr_i      (pop_rback_ptr_i),
        .pop_rback_mshr_hit_i (pop_rback_mshr_hit_i),
        .req_o                (req),
        .next_o               (next),
        .valid_o              (valid),
        .tail_o               (tail),
        .ready_o              (ready),
        .full_o               (full_o),
        .empty_o              (empty_o)
    );

    rtab_pop i_rtab_pop (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ready_i     (ready),
        .tail_i      (tail),
        .next_i      (next),
        .req_i       (req),
        .pop_ready_i (pop_ready_i),
        .pop_rback_i (pop_rback_i),
        .pop_valid_o (pop_valid_o),
        .pop_req_o   (pop_req_o),
        .pop_ptr_o   (pop_ptr_o),
        .take_o      (take)
    );

    // A link needs a live list on the checked line in the same cycle
    a_link_on_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc_link_i |-> (check_i && check_hit_o))
    else $error("rtab_top: link without a check hit");

endmodule

`default_nettype wire

// ==== testbench/rtab_tb.sv ====
// Testbench for the replay table top level.
// Runs the command list in testbench/rtab_patterns.txt, one command per
// line, and stops at the first mismatch or timeout.

`timescale 1ns/1ns
`default_nettype none

module rtab_tb
    import rtab_pkg::*;
();

    // Cycles to wait for a pop offer before giving up
    localparam int wait_limit = 20;

    logic        clk_i, rst_ni;
    logic        check_i, check_hit_o;
    logic        alloc_i, alloc_link_i, alloc_mshr_hit_i;
    logic        refill_i;
    logic        pop_valid_o, pop_ready_i;
    logic        pop_commit_i, pop_rback_i, pop_rback_mshr_hit_i;
    logic        full_o, empty_o;
    rtab_nline_t check_nline_i, refill_nline_i;
    rtab_req_t   alloc_req_i, pop_req_o;
    rtab_ptr_t   pop_ptr_o, pop_commit_ptr_i, pop_rback_ptr_i;

    int              fd;
    int              cmd_count;
    string           cmd;
    string           test_name;
    logic [8*128-1:0] skip;
    logic [31:0]     a0, a1, a2, a3, a4, a5;

    rtab_top i_rtab_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_req(input string what, input rtab_req_t exp, input rtab_req_t act);
        if (act !== exp) begin
            $display("** Error [%0s] %0s: expected nline %h data %h, actual nline %h data %h",
                     test_name, what, exp.nline, exp.data, act.nline, act.data);
            abort_run();
        end
    endtask

    task automatic check_ptr(input string what, input rtab_ptr_t exp, input rtab_ptr_t act);
        if (act !== exp) begin
            $display("** Error [%0s] %0s: expected %0d, actual %0d", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error [%0s] %0s: expected %b, actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic set_idle();
        check_i              = 1'b0;
        check_nline_i        = '0;
        alloc_i              = 1'b0;
        alloc_link_i         = 1'b0;
        alloc_req_i          = '0;
        alloc_mshr_hit_i     = 1'b0;
        refill_i             = 1'b0;
        refill_nline_i       = '0;
        pop_ready_i          = 1'b0;
        pop_commit_i         = 1'b0;
        pop_commit_ptr_i     = '0;
        pop_rback_i          = 1'b0;
        pop_rback_ptr_i      = '0;
        pop_rback_mshr_hit_i = 1'b0;
    endtask

    // Let the driven inputs act on one rising edge, then go idle
    task automatic step_cycle();
        @(posedge clk_i);
        @(negedge clk_i);
        set_idle();
    endtask

    task automatic alloc_entry(input logic link, input rtab_nline_t nline,
                               input rtab_data_t data, input logic dep);
        check_flag("full_o before allocation", 1'b0, full_o);
        check_i           = link;
        check_nline_i     = nline;
        alloc_i           = !link;
        alloc_link_i      = link;
        alloc_req_i.nline = nline;
        alloc_req_i.data  = data;
        alloc_mshr_hit_i  = dep;
        #1;
        if (link) begin
            check_flag("check_hit_o for link", 1'b1, check_hit_o);
        end
        step_cycle();
    endtask

    task automatic refill_line(input rtab_nline_t nline);
        refill_i       = 1'b1;
        refill_nline_i = nline;
        step_cycle();
    endtask

    task automatic check_flags(input rtab_nline_t nline, input logic full, input logic empty,
                               input logic hit, input logic valid);
        check_i       = 1'b1;
        check_nline_i = nline;
        #1;
        check_flag("full_o", full, full_o);
        check_flag("empty_o", empty, empty_o);
        check_flag("check_hit_o", hit, check_hit_o);
        check_flag("pop_valid_o", valid, pop_valid_o);
        step_cycle();
    endtask

    task automatic pop_entry(input rtab_nline_t nline, input rtab_data_t data,
                             input rtab_ptr_t ptr, input int stall,
                             input logic rback, input logic dep);
        rtab_req_t exp_req;
        rtab_req_t held_req;
        rtab_ptr_t held_ptr;
        int        waited;
        exp_req.nline = nline;
        exp_req.data  = data;
        waited        = 0;
        #1;
        while (pop_valid_o !== 1'b1) begin
            if (waited == wait_limit) begin
                $display("Timeout in %0s: no pop offer within %0d cycles", test_name, waited);
                abort_run();
            end
            @(negedge clk_i);
            #1;
            waited++;
        end
        held_req = pop_req_o;
        held_ptr = pop_ptr_o;
        // With pop_ready_i low the offer has to stay put
        repeat (stall) begin
            @(negedge clk_i);
            #1;
            check_flag("pop_valid_o under back-pressure", 1'b1, pop_valid_o);
            check_req("pop_req_o under back-pressure", held_req, pop_req_o);
            check_ptr("pop_ptr_o under back-pressure", held_ptr, pop_ptr_o);
        end
        @(negedge clk_i);
        pop_ready_i = 1'b1;
        #1;
        check_flag("pop_valid_o at transfer", 1'b1, pop_valid_o);
        check_req("pop_req_o", exp_req, pop_req_o);
        check_ptr("pop_ptr_o", ptr, pop_ptr_o);
        @(posedge clk_i);
        @(negedge clk_i);
        // Close the transfer in the very next cycle
        pop_ready_i          = 1'b0;
        pop_commit_i         = !rback;
        pop_commit_ptr_i     = ptr;
        pop_rback_i          = rback;
        pop_rback_ptr_i      = ptr;
        pop_rback_mshr_hit_i = dep;
        step_cycle();
    endtask

    task automatic expect_args(input int got, input int want);
        if (got != want) begin
            $display("Pattern line %0s has %0d values instead of %0d", cmd, got, want);
            abort_run();
        end
    endtask

    task automatic run_command();
        int n;
        if (cmd == "#") begin
            n = $fgets(skip, fd);
        end else if (cmd == "TEST") begin
            n = $fscanf(fd, "%s", test_name);
            expect_args(n, 1);
        end else if (cmd == "ALLOC" || cmd == "LINK") begin
            n = $fscanf(fd, "%h %h %h", a0, a1, a2);
            expect_args(n, 3);
            alloc_entry(cmd == "LINK", rtab_nline_t'(a0), rtab_data_t'(a1), a2[0]);
        end else if (cmd == "REFILL") begin
            n = $fscanf(fd, "%h", a0);
            expect_args(n, 1);
            refill_line(rtab_nline_t'(a0));
        end else if (cmd == "POP") begin
            n = $fscanf(fd, "%h %h %h %h %h %h", a0, a1, a2, a3, a4, a5);
            expect_args(n, 6);
            pop_entry(rtab_nline_t'(a0), rtab_data_t'(a1), rtab_ptr_t'(a2), int'(a3),
                      a4[0], a5[0]);
        end else if (cmd == "FLAGS") begin
            n = $fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, a4);
            expect_args(n, 5);
            check_flags(rtab_nline_t'(a0), a1[0], a2[0], a3[0], a4[0]);
        end else begin
            $display("Unknown command %0s in the pattern file", cmd);
            abort_run();
        end
    endtask

    initial begin
        set_idle();
        rst_ni    = 1'b0;
        test_name = "reset";
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        fd = $fopen("testbench/rtab_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/rtab_patterns.txt");
            abort_run();
        end
        cmd_count = 0;
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd != "#") begin
                cmd_count++;
            end
            run_command();
        end
        $fclose(fd);
        if (cmd_count == 0) begin
            $display("The pattern file holds no commands");
            abort_run();
        end else begin
            $display("%0d commands executed", cmd_count);
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/rtab_patterns.txt ====
# ALLOC|LINK nline data dep ; REFILL nline ; FLAGS nline full empty hit pop_valid
# POP nline data ptr stall rback dep (rback 0 commits) ; TEST name ; values in hex
TEST alloc_pop
FLAGS 00 0 1 0 0
ALLOC 10 1111 0
FLAGS 10 0 0 1 1
POP 10 1111 0 0 0 0
FLAGS 10 0 1 0 0
TEST link_backpressure
ALLOC 20 2001 0
LINK 20 2002 0
LINK 20 2003 0
POP 20 2001 0 0 0 0
FLAGS 20 0 0 1 1
POP 20 2002 1 3 0 0
POP 20 2003 2 2 0 0
FLAGS 20 0 1 0 0
TEST dependency
ALLOC 30 3001 1
FLAGS 30 0 0 1 0
REFILL 31
FLAGS 30 0 0 1 0
REFILL 30
POP 30 3001 0 0 0 0
TEST rollback
ALLOC 40 4001 0
POP 40 4001 0 0 1 1
FLAGS 40 0 0 1 0
REFILL 40
POP 40 4001 0 0 1 0
POP 40 4001 0 0 0 0
FLAGS 40 0 1 0 0
TEST capacity
ALLOC 50 5000 0
ALLOC 51 5101 0
ALLOC 52 5202 0
ALLOC 53 5303 0
FLAGS 53 1 0 1 1
POP 51 5101 1 0 0 0
ALLOC 54 5404 0
POP 52 5202 2 0 0 0
POP 53 5303 3 0 0 0
POP 50 5000 0 0 0 0
POP 54 5404 1 0 0 0
FLAGS 54 0 1 0 0

// ==== files.f ====
+incdir+common
common/rtab_pkg.sv
rtab/rtab_match.sv
rtab/rtab_store.sv
rtab/rtab_pop.sv
verilog/rtab_top.sv
testbench/rtab_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rtab_tb
FLIST     ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
